//--- Bender.yml
package:
  name: or1k_lite

sources:
  - or1k_lite_pkg.sv
  - or1k_lite_fetch.sv
  - or1k_lite_decode.sv
  - or1k_lite_regfile.sv
  - or1k_lite_execute.sv
  - or1k_lite_retire.sv
  - or1k_lite_top.sv
  - target: simulation
    files:
      - or1k_lite_tb_clk.sv
      - or1k_lite_assert.sv
      - or1k_lite_tb.sv

//--- or1k_lite.f
or1k_lite_pkg.sv
or1k_lite_fetch.sv
or1k_lite_decode.sv
or1k_lite_regfile.sv
or1k_lite_execute.sv
or1k_lite_retire.sv
or1k_lite_top.sv
or1k_lite_tb_clk.sv
or1k_lite_assert.sv
or1k_lite_tb.sv

//--- or1k_lite_assert.sv
`timescale 1ns/1ps

module or1k_lite_assert (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  or1k_lite_pkg::insn_beat_t insn_i,
	input  logic                      credit_i,
	input  or1k_lite_pkg::gpr_wb_t    wb_i,
	input  or1k_lite_pkg::except_t    except_i
);

	import or1k_lite_pkg::*;

	int fail_cnt = 0;
	int in_flight_q;

	// Beats captured whose credit has not come back yet
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			in_flight_q <= 0;
		end else begin
			in_flight_q <= in_flight_q + int'(insn_i.valid) - int'(credit_i);
		end
	end

	a_one_report: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(wb_i.valid && except_i.valid))
	else begin
		$error("wb and except reports valid together");
		fail_cnt++;
	end

	a_quiet_in_reset: assert property (@(posedge clk)
		!rst_n_i |-> !wb_i.valid && !except_i.valid && !credit_i)
	else begin
		$error("output valid during reset");
		fail_cnt++;
	end

	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
		in_flight_q <= INSN_CREDITS)
	else begin
		$error("more beats in flight than credits");
		fail_cnt++;
	end

endmodule

bind or1k_lite_top or1k_lite_assert u_assert (
	.clk      (clk),
	.rst_n_i  (rst_n_i),
	.insn_i   (insn_i),
	.credit_i (credit_o),
	.wb_i     (wb_o),
	.except_i (except_o)
);

//--- or1k_lite_decode.sv
`timescale 1ns/1ps

module or1k_lite_decode (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  or1k_lite_pkg::insn_beat_t           head_i,
	input  logic [or1k_lite_pkg::XLEN-1:0]      head_pc_i,
	output logic                                pop_o,
	output or1k_lite_pkg::id_ex_t               id_ex_o
);

	import or1k_lite_pkg::*;

	id_ex_t id_ex_d;
	id_ex_t id_ex_q;
	rr_fmt_t rr;
	ri_fmt_t ri;

	assign rr = head_i.word.rr_fmt;
	assign ri = head_i.word.ri_fmt;

	// No stalls, so a valid head is always taken
	assign pop_o = head_i.valid;

	always_comb begin
		id_ex_d = '0;
		id_ex_d.valid = head_i.valid;
		id_ex_d.pc = head_pc_i;
		id_ex_d.alu_op = ADD;
		id_ex_d.rd = ri.rd;
		id_ex_d.ra = ri.ra;
		id_ex_d.rb = rr.rb;
		id_ex_d.use_imm = 1'b1;
		id_ex_d.cause = ILLEGAL;

		case (ri.opcode)
			OPC_MOVHI: begin
				id_ex_d.alu_op = MOVHI;
				id_ex_d.imm = {ri.imm, 16'h0000};
				id_ex_d.cause = NONE;
			end
			OPC_ADDI: begin
				id_ex_d.alu_op = ADD;
				id_ex_d.imm = {{16{ri.imm[15]}}, ri.imm};
				id_ex_d.check_ovf = 1'b1;
				id_ex_d.cause = NONE;
			end
			OPC_ANDI: begin
				id_ex_d.alu_op = AND;
				id_ex_d.imm = {16'h0000, ri.imm};
				id_ex_d.cause = NONE;
			end
			OPC_ORI: begin
				id_ex_d.alu_op = OR;
				id_ex_d.imm = {16'h0000, ri.imm};
				id_ex_d.cause = NONE;
			end
			OPC_XORI: begin
				id_ex_d.alu_op = XOR;
				id_ex_d.imm = {16'h0000, ri.imm};
				id_ex_d.cause = NONE;
			end
			OPC_SYS: begin
				// rd and ra fields hold bits 25:16
				if ({ri.rd, ri.ra} == SYS_TAG) begin
					id_ex_d.cause = SYSCALL;
				end
			end
			OPC_ALU: begin
				id_ex_d.use_imm = 1'b0;
				id_ex_d.cause = NONE;
				case (rr.sub_op)
					ALU_ADD: begin
						id_ex_d.alu_op = ADD;
						id_ex_d.check_ovf = 1'b1;
					end
					ALU_SUB: begin
						id_ex_d.alu_op = SUB;
						id_ex_d.check_ovf = 1'b1;
					end
					ALU_AND: id_ex_d.alu_op = AND;
					ALU_OR:  id_ex_d.alu_op = OR;
					ALU_XOR: id_ex_d.alu_op = XOR;
					default: id_ex_d.cause = ILLEGAL;
				endcase
			end
			default: id_ex_d.cause = ILLEGAL;
		endcase

		// Excepting instructions never write back
		id_ex_d.writes_rd = (id_ex_d.cause == NONE);
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_ex_q <= '0;
		end else begin
			id_ex_q <= id_ex_d;
		end
	end

	assign id_ex_o = id_ex_q;

endmodule

//--- or1k_lite_execute.sv
`timescale 1ns/1ps

module or1k_lite_execute (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  or1k_lite_pkg::id_ex_t               id_ex_i,
	input  logic [or1k_lite_pkg::XLEN-1:0]      ra_data_i,
	input  logic [or1k_lite_pkg::XLEN-1:0]      rb_data_i,
	input  or1k_lite_pkg::ex_rt_t               rt_fwd_i,
	output logic [or1k_lite_pkg::REG_AW-1:0]    ra_addr_o,
	output logic [or1k_lite_pkg::REG_AW-1:0]    rb_addr_o,
	output or1k_lite_pkg::ex_rt_t               ex_rt_o
);

	import or1k_lite_pkg::*;

	ex_rt_t ex_rt_d;
	ex_rt_t ex_rt_q;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] rb_val;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;
	logic [XLEN-1:0] result;
	logic add_ovf;
	logic sub_ovf;
	logic ovf;

	// Newest producer wins. The own register covers distance one,
	// the retire record covers the cycle its write is still pending.
	function automatic logic [XLEN-1:0] fwd_sel(input logic [REG_AW-1:0] addr,
		input logic [XLEN-1:0] rf_data);
		if (addr == '0) begin
			return rf_data;
		end
		if (ex_rt_q.valid && ex_rt_q.writes_rd && (ex_rt_q.rd == addr)) begin
			return ex_rt_q.result;
		end
		if (rt_fwd_i.valid && rt_fwd_i.writes_rd && (rt_fwd_i.rd == addr)) begin
			return rt_fwd_i.result;
		end
		return rf_data;
	endfunction

	assign ra_addr_o = id_ex_i.ra;
	assign rb_addr_o = id_ex_i.rb;

	always_comb begin
		op_a = fwd_sel(id_ex_i.ra, ra_data_i);
		rb_val = fwd_sel(id_ex_i.rb, rb_data_i);
	end

	assign op_b = id_ex_i.use_imm ? id_ex_i.imm : rb_val;

	assign sum = op_a + op_b;
	assign diff = op_a - op_b;

	// Signed overflow from operand and result signs
	assign add_ovf = (op_a[XLEN-1] == op_b[XLEN-1]) && (sum[XLEN-1] != op_a[XLEN-1]);
	assign sub_ovf = (op_a[XLEN-1] != op_b[XLEN-1]) && (diff[XLEN-1] != op_a[XLEN-1]);
	assign ovf = id_ex_i.check_ovf &&
		(((id_ex_i.alu_op == ADD) && add_ovf) || ((id_ex_i.alu_op == SUB) && sub_ovf));

	always_comb begin
		case (id_ex_i.alu_op)
			ADD:     result = sum;
			SUB:     result = diff;
			AND:     result = op_a & op_b;
			OR:      result = op_a | op_b;
			XOR:     result = op_a ^ op_b;
			MOVHI:   result = op_b;
			default: result = sum;
		endcase
	end

	always_comb begin
		ex_rt_d.valid = id_ex_i.valid;
		ex_rt_d.pc = id_ex_i.pc;
		ex_rt_d.rd = id_ex_i.rd;
		ex_rt_d.result = result;
		ex_rt_d.writes_rd = id_ex_i.writes_rd && !ovf;
		ex_rt_d.cause = ovf ? RANGE : id_ex_i.cause;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_rt_q <= '0;
		end else begin
			ex_rt_q <= ex_rt_d;
		end
	end

	assign ex_rt_o = ex_rt_q;

endmodule

//--- or1k_lite_fetch.sv
`timescale 1ns/1ps

module or1k_lite_fetch (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  or1k_lite_pkg::insn_beat_t           insn_i,
	input  logic                                pop_i,
	output or1k_lite_pkg::insn_beat_t           head_o,
	output logic [or1k_lite_pkg::XLEN-1:0]      head_pc_o,
	output logic                                credit_o
);

	import or1k_lite_pkg::*;

	insn_u mem_q [INSN_CREDITS];

	// One extra pointer bit tells full from empty
	logic [INSN_PTR_W:0] wr_ptr_q;
	logic [INSN_PTR_W:0] rd_ptr_q;
	logic [XLEN-1:0] pc_q;
	logic credit_q;
	logic empty;
	logic do_pop;

	assign empty = (wr_ptr_q == rd_ptr_q);
	assign do_pop = pop_i && !empty;

	always_ff @(posedge clk) begin
		if (insn_i.valid) begin
			mem_q[wr_ptr_q[INSN_PTR_W-1:0]] <= insn_i.word;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (insn_i.valid) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	// PC of the head entry, one word per popped instruction
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= BOOT_ADR;
		end else if (do_pop) begin
			pc_q <= pc_q + 32'd4;
		end
	end

	// Each pop hands one credit back to the sender
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			credit_q <= 1'b0;
		end else begin
			credit_q <= do_pop;
		end
	end

	always_comb begin
		head_o.valid = !empty;
		head_o.word = mem_q[rd_ptr_q[INSN_PTR_W-1:0]];
	end

	assign head_pc_o = pc_q;
	assign credit_o = credit_q;

endmodule

//--- or1k_lite_pkg.sv
package or1k_lite_pkg;

	// Widths and boot address
	localparam int XLEN = 32;
	localparam int REG_AW = 5;
	localparam logic [XLEN-1:0] BOOT_ADR = 32'h0000_0100;

	// Instruction buffer depth, equal to the sender's credits after reset
	localparam int INSN_CREDITS = 4;
	localparam int INSN_PTR_W = $clog2(INSN_CREDITS);

	// Major opcodes, bits 31:26
	localparam logic [5:0] OPC_MOVHI = 6'h06;
	localparam logic [5:0] OPC_SYS = 6'h08;
	localparam logic [5:0] OPC_ADDI = 6'h27;
	localparam logic [5:0] OPC_ANDI = 6'h29;
	localparam logic [5:0] OPC_ORI = 6'h2A;
	localparam logic [5:0] OPC_XORI = 6'h2B;
	localparam logic [5:0] OPC_ALU = 6'h38;

	// l.sys also needs this pattern in bits 25:16
	localparam logic [9:0] SYS_TAG = 10'h200;

	// Register-register sub-ops, bits 3:0
	localparam logic [3:0] ALU_ADD = 4'h0;
	localparam logic [3:0] ALU_SUB = 4'h2;
	localparam logic [3:0] ALU_AND = 4'h3;
	localparam logic [3:0] ALU_OR = 4'h4;
	localparam logic [3:0] ALU_XOR = 4'h5;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rd;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [6:0] unused;
		logic [3:0] sub_op;
	} rr_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rd;
		logic [4:0] ra;
		logic [15:0] imm;
	} ri_fmt_t;

	// Same word seen as register-register or register-immediate
	typedef union packed {
		rr_fmt_t rr_fmt;
		ri_fmt_t ri_fmt;
	} insn_u;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		MOVHI
	} alu_op_e;

	typedef enum logic [1:0] {
		NONE,
		ILLEGAL,
		RANGE,
		SYSCALL
	} cause_e;

	typedef struct packed {
		logic valid;
		insn_u word;
	} insn_beat_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		alu_op_e alu_op;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] ra;
		logic [REG_AW-1:0] rb;
		logic use_imm;
		logic [XLEN-1:0] imm;
		logic writes_rd;
		logic check_ovf;
		cause_e cause;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0] result;
		logic writes_rd;
		cause_e cause;
	} ex_rt_t;

	typedef struct packed {
		logic valid;
		logic [REG_AW-1:0] addr;
		logic [XLEN-1:0] data;
	} gpr_wb_t;

	typedef struct packed {
		logic valid;
		cause_e cause;
		logic [XLEN-1:0] epcr;
	} except_t;

endpackage

//--- or1k_lite_regfile.sv
`timescale 1ns/1ps

module or1k_lite_regfile (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic [or1k_lite_pkg::REG_AW-1:0]    ra_addr_i,
	input  logic [or1k_lite_pkg::REG_AW-1:0]    rb_addr_i,
	input  or1k_lite_pkg::gpr_wb_t              wr_i,
	output logic [or1k_lite_pkg::XLEN-1:0]      ra_data_o,
	output logic [or1k_lite_pkg::XLEN-1:0]      rb_data_o
);

	import or1k_lite_pkg::*;

	logic [XLEN-1:0] gpr_q [2**REG_AW];

	// r0 is never written, so it stays at its reset value of zero
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				gpr_q[i] <= '0;
			end
		end else if (wr_i.valid && (wr_i.addr != '0)) begin
			gpr_q[wr_i.addr] <= wr_i.data;
		end
	end

	assign ra_data_o = gpr_q[ra_addr_i];
	assign rb_data_o = gpr_q[rb_addr_i];

endmodule

//--- or1k_lite_retire.sv
`timescale 1ns/1ps

module or1k_lite_retire (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  or1k_lite_pkg::ex_rt_t               ex_rt_i,
	output or1k_lite_pkg::ex_rt_t               rt_o,
	output or1k_lite_pkg::gpr_wb_t              wb_o,
	output or1k_lite_pkg::except_t              except_o
);

	import or1k_lite_pkg::*;

	ex_rt_t rt_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rt_q <= '0;
		end else begin
			rt_q <= ex_rt_i;
		end
	end

	// Write-back report doubles as the register file write port
	always_comb begin
		wb_o.valid = rt_q.valid && rt_q.writes_rd;
		wb_o.addr = rt_q.rd;
		wb_o.data = rt_q.result;
	end

	always_comb begin
		except_o.valid = rt_q.valid && (rt_q.cause != NONE);
		except_o.cause = rt_q.cause;
		except_o.epcr = rt_q.pc;
	end

	// Forwarding source for execute
	assign rt_o = rt_q;

endmodule

//--- or1k_lite_tb.sv
`timescale 1ns/1ps

module or1k_lite_tb;

	import or1k_lite_pkg::*;

	localparam int MAX_ENTRIES = 32;
	localparam int DRIVE_DLY = 2;
	localparam int FIRST_LAT = 4;
	localparam int QUIET_CYCLES = 6;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst_n;
	insn_beat_t insn_i;
	logic credit_o;
	gpr_wb_t wb_o;
	except_t except_o;

	insn_u tbl_word [MAX_ENTRIES];
	logic tbl_is_exc [MAX_ENTRIES];
	logic [REG_AW-1:0] tbl_rd [MAX_ENTRIES];
	logic [XLEN-1:0] tbl_data [MAX_ENTRIES];
	cause_e tbl_cause [MAX_ENTRIES];
	int cap_cyc [MAX_ENTRIES];

	int n_entries = 0;
	int sent_cnt = 0;
	int rep_cnt = 0;
	int credits = INSN_CREDITS;
	int cyc = 0;
	int value_errs = 0;
	int proto_errs = 0;
	int total_errs;
	logic [31:0] rng_q = 32'h5e29_68f2;

	or1k_lite_tb_clk u_clk (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	or1k_lite_top dut (
		.clk      (clk),
		.rst_n_i  (rst_n),
		.insn_i   (insn_i),
		.credit_o (credit_o),
		.wb_o     (wb_o),
		.except_o (except_o)
	);

	function automatic logic [31:0] enc_ri(input logic [5:0] opc, input int rd, input int ra,
		input logic [15:0] imm);
		return {opc, 5'(rd), 5'(ra), imm};
	endfunction

	function automatic logic [31:0] enc_rr(input int rd, input int ra, input int rb,
		input logic [3:0] sub_op);
		return {OPC_ALU, 5'(rd), 5'(ra), 5'(rb), 7'h00, sub_op};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic add_wb(input logic [31:0] w, input int rd, input logic [XLEN-1:0] data);
		tbl_word[n_entries] = w;
		tbl_is_exc[n_entries] = 1'b0;
		tbl_rd[n_entries] = REG_AW'(rd);
		tbl_data[n_entries] = data;
		tbl_cause[n_entries] = NONE;
		n_entries++;
	endtask

	task automatic add_exc(input logic [31:0] w, input cause_e cause);
		tbl_word[n_entries] = w;
		tbl_is_exc[n_entries] = 1'b1;
		tbl_rd[n_entries] = '0;
		tbl_data[n_entries] = '0;
		tbl_cause[n_entries] = cause;
		n_entries++;
	endtask

	task automatic fill_table();
		add_wb(enc_ri(OPC_MOVHI, 1, 0, 16'h1234), 1, 32'h1234_0000);
		add_wb(enc_ri(OPC_ORI, 1, 1, 16'h5678), 1, 32'h1234_5678);
		add_wb(enc_ri(OPC_ANDI, 2, 1, 16'h0FF0), 2, 32'h0000_0670);
		add_wb(enc_ri(OPC_XORI, 3, 1, 16'hFFFF), 3, 32'h1234_A987);
		add_wb(enc_ri(OPC_ADDI, 4, 0, 16'hFFFF), 4, 32'hFFFF_FFFF);
		add_wb(enc_ri(OPC_ADDI, 5, 4, 16'h0010), 5, 32'h0000_000F);
		add_wb(enc_rr(6, 1, 3, ALU_ADD), 6, 32'h2468_FFFF);
		add_wb(enc_rr(7, 6, 1, ALU_SUB), 7, 32'h1234_A987);
		add_wb(enc_rr(8, 6, 3, ALU_AND), 8, 32'h0020_A987);
		add_wb(enc_rr(9, 8, 2, ALU_OR), 9, 32'h0020_AFF7);
		add_wb(enc_rr(10, 9, 1, ALU_XOR), 10, 32'h1214_F98F);
		// Write to r0 still reports, the read after it sees zero
		add_wb(enc_ri(OPC_ADDI, 0, 1, 16'h0001), 0, 32'h1234_5679);
		add_wb(enc_rr(11, 0, 1, ALU_ADD), 11, 32'h1234_5678);
		add_exc(enc_ri(6'h3F, 1, 0, 16'h0000), ILLEGAL);
		add_wb(enc_rr(12, 1, 0, ALU_OR), 12, 32'h1234_5678);
		add_exc(enc_ri(OPC_SYS, 16, 0, 16'h0000), SYSCALL);
		add_wb(enc_ri(OPC_MOVHI, 13, 0, 16'h7FFF), 13, 32'h7FFF_0000);
		add_wb(enc_ri(OPC_ORI, 13, 13, 16'hFFFF), 13, 32'h7FFF_FFFF);
		add_exc(enc_rr(13, 13, 13, ALU_ADD), RANGE);
		add_wb(enc_ri(OPC_ORI, 14, 13, 16'h0000), 14, 32'h7FFF_FFFF);
		add_wb(enc_ri(OPC_MOVHI, 16, 0, 16'h8000), 16, 32'h8000_0000);
		add_exc(enc_rr(17, 16, 5, ALU_SUB), RANGE);
		add_exc(enc_rr(2, 1, 1, 4'hF), ILLEGAL);
		add_wb(enc_rr(18, 2, 17, ALU_ADD), 18, 32'h0000_0670);
		add_wb(enc_rr(19, 13, 4, ALU_XOR), 19, 32'h8000_0000);
		// l.sys without its tag in bits 25:16
		add_exc(enc_ri(OPC_SYS, 0, 0, 16'h0000), ILLEGAL);
	endtask

	task automatic check_wb(input gpr_wb_t got, input gpr_wb_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t wb_o got valid=%0b addr=%0d data=%08h, exp valid=%0b addr=%0d data=%08h",
				$time, got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data);
			value_errs++;
		end
	endtask

	task automatic check_except(input except_t got, input except_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t except_o got valid=%0b cause=%s epcr=%08h, exp valid=%0b cause=%s epcr=%08h",
				$time, got.valid, got.cause.name(), got.epcr, exp.valid, exp.cause.name(), exp.epcr);
			value_errs++;
		end
	endtask

	task automatic take_report();
		gpr_wb_t exp_wb;
		except_t exp_exc;
		int lat;
		if (wb_o.valid && except_o.valid) begin
			$display("%0t: wb_o and except_o are valid in the same cycle", $time);
			proto_errs++;
		end
		if (rep_cnt >= sent_cnt) begin
			$display("%0t: a report came with no instruction outstanding", $time);
			proto_errs++;
		end else begin
			if (tbl_is_exc[rep_cnt] && !except_o.valid) begin
				$display("%0t: entry %0d gave a write-back instead of an exception", $time, rep_cnt);
				proto_errs++;
			end else if (!tbl_is_exc[rep_cnt] && !wb_o.valid) begin
				$display("%0t: entry %0d gave an exception instead of a write-back", $time, rep_cnt);
				proto_errs++;
			end else if (tbl_is_exc[rep_cnt]) begin
				exp_exc.valid = 1'b1;
				exp_exc.cause = tbl_cause[rep_cnt];
				exp_exc.epcr = BOOT_ADR + 32'(rep_cnt * 4);
				check_except(except_o, exp_exc);
			end else begin
				exp_wb.valid = 1'b1;
				exp_wb.addr = tbl_rd[rep_cnt];
				exp_wb.data = tbl_data[rep_cnt];
				check_wb(wb_o, exp_wb);
			end
			// The edge after this negedge is the one that takes the report
			lat = cyc + 1 - cap_cyc[rep_cnt];
			if (rep_cnt == 0 && lat != FIRST_LAT) begin
				$display("%0t: first report took %0d cycles instead of %0d", $time, lat, FIRST_LAT);
				proto_errs++;
			end
			rep_cnt++;
		end
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// Outputs are sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (credit_o) begin
				credits++;
				if (credits > INSN_CREDITS) begin
					$display("%0t: more credits returned than were spent", $time);
					proto_errs++;
				end
			end
			if (wb_o.valid || except_o.valid) begin
				take_report();
			end
		end
	end

	task automatic idle_cycle();
		@(posedge clk);
		#DRIVE_DLY;
		insn_i = '0;
	endtask

	task automatic drive_beat(input insn_u w);
		@(posedge clk);
		#DRIVE_DLY;
		insn_i.valid = 1'b1;
		insn_i.word = w;
		credits--;
		cap_cyc[sent_cnt] = cyc + 1;
		sent_cnt++;
	endtask

	task automatic wait_credit(output logic ok);
		int waited;
		waited = 0;
		ok = 1'b1;
		while (credits == 0) begin
			if (waited >= WAIT_LIMIT) begin
				$display("%0t: no credit came back within %0d cycles", $time, WAIT_LIMIT);
				proto_errs++;
				ok = 1'b0;
				break;
			end
			idle_cycle();
			waited++;
		end
	endtask

	task automatic run_stream();
		int gap;
		logic ok;
		for (int i = 0; i < n_entries; i++) begin
			// Mostly back-to-back bursts, now and then a short gap
			rng_q = lcg_next(rng_q);
			gap = (i == 0 || rng_q[31:29] < 3'd5) ? 0 : int'(rng_q[27:26]) + 1;
			repeat (gap) idle_cycle();
			wait_credit(ok);
			if (!ok) begin
				break;
			end
			drive_beat(tbl_word[i]);
		end
		idle_cycle();
	endtask

	task automatic wait_reset();
		int waited;
		waited = 0;
		while (rst_n !== 1'b1) begin
			if (waited >= WAIT_LIMIT) begin
				$display("%0t: reset was never released", $time);
				proto_errs++;
				break;
			end
			@(posedge clk);
			waited++;
		end
	endtask

	task automatic wait_reports();
		int waited;
		waited = 0;
		while (rep_cnt < sent_cnt) begin
			if (waited >= WAIT_LIMIT) begin
				$display("%0t: %0d of %0d reports seen before timeout", $time, rep_cnt, sent_cnt);
				proto_errs++;
				break;
			end
			idle_cycle();
			waited++;
		end
	endtask

	initial begin
		insn_i = '0;
		fill_table();
		wait_reset();
		// Nothing may report while no instruction has been sent
		repeat (QUIET_CYCLES) idle_cycle();
		run_stream();
		wait_reports();
		repeat (8) idle_cycle();
		if (sent_cnt != n_entries) begin
			$display("only %0d of %0d entries were sent", sent_cnt, n_entries);
			proto_errs++;
		end
		if (credits != INSN_CREDITS) begin
			$display("sender holds %0d credits at the end, not %0d", credits, INSN_CREDITS);
			proto_errs++;
		end
		total_errs = value_errs + proto_errs + dut.u_assert.fail_cnt;
		$display("Errors: value %0d, protocol %0d, assertion %0d",
			value_errs, proto_errs, dut.u_assert.fail_cnt);
		if (total_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- or1k_lite_tb_clk.sv
`timescale 1ns/1ps

module or1k_lite_tb_clk (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int RST_CYCLES = 10;

	// 40 ns period
	initial begin
		clk_o = 1'b0;
		forever begin
			#20 clk_o = ~clk_o;
		end
	end

	// Release on a falling edge, clear of the flops' sampling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

//--- or1k_lite_top.sv
`timescale 1ns/1ps

module or1k_lite_top (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  or1k_lite_pkg::insn_beat_t           insn_i,
	output logic                                credit_o,
	output or1k_lite_pkg::gpr_wb_t              wb_o,
	output or1k_lite_pkg::except_t              except_o
);

	import or1k_lite_pkg::*;

	insn_beat_t head;
	logic [XLEN-1:0] head_pc;
	logic pop;
	id_ex_t id_ex;
	ex_rt_t ex_rt;
	ex_rt_t rt;
	logic [REG_AW-1:0] ra_addr;
	logic [REG_AW-1:0] rb_addr;
	logic [XLEN-1:0] ra_data;
	logic [XLEN-1:0] rb_data;

	or1k_lite_fetch u_fetch (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.insn_i    (insn_i),
		.pop_i     (pop),
		.head_o    (head),
		.head_pc_o (head_pc),
		.credit_o  (credit_o)
	);

	or1k_lite_decode u_decode (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.head_i    (head),
		.head_pc_i (head_pc),
		.pop_o     (pop),
		.id_ex_o   (id_ex)
	);

	or1k_lite_regfile u_regfile (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.ra_addr_i (ra_addr),
		.rb_addr_i (rb_addr),
		.wr_i      (wb_o),
		.ra_data_o (ra_data),
		.rb_data_o (rb_data)
	);

	or1k_lite_execute u_execute (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.id_ex_i   (id_ex),
		.ra_data_i (ra_data),
		.rb_data_i (rb_data),
		.rt_fwd_i  (rt),
		.ra_addr_o (ra_addr),
		.rb_addr_o (rb_addr),
		.ex_rt_o   (ex_rt)
	);

	or1k_lite_retire u_retire (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.ex_rt_i   (ex_rt),
		.rt_o      (rt),
		.wb_o      (wb_o),
		.except_o  (except_o)
	);

endmodule
